// ==== verilog/loader_pkg.sv ====
/*
 * Shared widths, constants and packed structs of the download loader.
 * Every loader file and the testbench refer to these by scoped names.
 */
`default_nettype none

package loader_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int LOAD_ADDR_W = 25;
	localparam int DL_DATA_W   = 8;

	// Download index values
	localparam logic [7:0] IDX_PRG = 8'd2;
	localparam logic [7:0] IDX_CRT = 8'd3;

	// ==============================
	// CRT image layout
	// ==============================
	localparam logic [LOAD_ADDR_W-1:0] CRT_ROM_BASE = 25'h100000;

	localparam logic [7:0] CRT_OFS_ID_HI = 8'h16;
	localparam logic [7:0] CRT_OFS_ID_LO = 8'h17;
	localparam logic [7:0] CRT_OFS_EXROM = 8'h18;
	localparam logic [7:0] CRT_OFS_GAME  = 8'h19;
	localparam logic [7:0] CRT_OFS_CHIPS = 8'h40;

	// Chip packets start on an 8 KB boundary
	localparam int BANK_ALIGN_BITS = 13;
	localparam int CHIP_HDR_BYTES  = 16;

	// One pending memory write
	typedef struct packed {
		logic [LOAD_ADDR_W-1:0] addr;
		logic [DL_DATA_W-1:0]   data;
	} mem_wr_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	// Bank record taken from one chip packet header
	typedef struct packed {
		logic [7:0]             bank_type;
		logic [15:0]            bank_num;
		logic [15:0]            load_addr;
		logic [15:0]            size;
		logic [LOAD_ADDR_W-1:0] rom_base;
	} bank_hdr_t;

endpackage

`default_nettype wire

// ==== verilog/load_parser.sv ====
/*
 * First loader stage. Decodes the host's download bytes: PRG images give a
 * load address and data, CRT images give cartridge info, one bank record per
 * chip packet and packet data. Each data byte becomes one queued memory write.
 */
`timescale 1ns/1ps
`default_nettype none

module load_parser (
	input  wire                                      clk32,
	input  wire                                      rst_n_i,
	input  wire                                      dl_active_i,
	input  wire [7:0]                                dl_index_i,
	input  wire                                      dl_wr_i,
	input  wire [loader_pkg::LOAD_ADDR_W-1:0]        dl_addr_i,
	input  wire [loader_pkg::DL_DATA_W-1:0]          dl_data_i,
	output loader_pkg::mem_wr_t                      wr_req_o,
	output logic                                     push_o,
	output loader_pkg::cart_info_t                   cart_info_o,
	output loader_pkg::bank_hdr_t                    bank_hdr_o,
	output logic                                     bank_hdr_wr_o
);

	localparam int AW  = loader_pkg::LOAD_ADDR_W;
	localparam int AB  = loader_pkg::BANK_ALIGN_BITS;
	localparam int HCW = $clog2(loader_pkg::CHIP_HDR_BYTES);

	localparam logic [HCW-1:0] HDR_LAST = HCW'(loader_pkg::CHIP_HDR_BYTES - 1);

	logic [AW-1:0]  load_addr;
	logic [31:0]    blk_len;
	logic [HCW-1:0] hdr_cnt;

	logic byte_wr;
	logic is_prg;
	logic is_crt;
	logic in_chips;
	logic hdr_start;
	logic in_hdr;
	logic prg_data;
	logic crt_data;
	logic data_push;

	// ==============================
	// Byte decode
	// ==============================
	always_comb begin
		byte_wr   = dl_wr_i & dl_active_i;
		is_prg    = byte_wr && (dl_index_i == loader_pkg::IDX_PRG);
		is_crt    = byte_wr && (dl_index_i == loader_pkg::IDX_CRT);
		in_chips  = is_crt && (dl_addr_i >= AW'(loader_pkg::CRT_OFS_CHIPS));
		// A new packet starts when the previous one is used up
		hdr_start = in_chips && (blk_len == '0) && (hdr_cnt == '0);
		in_hdr    = in_chips && (hdr_cnt != '0);
		prg_data  = is_prg && (dl_addr_i > AW'(1));
		crt_data  = in_chips && !hdr_start && !in_hdr;
		data_push = prg_data | crt_data;
	end

	// ==============================
	// Control state
	// ==============================
	always_ff @(posedge clk32) begin
		if (!rst_n_i) begin
			load_addr     <= '0;
			blk_len       <= '0;
			hdr_cnt       <= '0;
			push_o        <= 1'b0;
			bank_hdr_wr_o <= 1'b0;
			cart_info_o   <= '0;
		end else begin
			push_o        <= data_push;
			bank_hdr_wr_o <= in_hdr && (hdr_cnt == HDR_LAST);

			if (is_prg) begin
				// Offsets 0 and 1 carry the little-endian load address
				if (dl_addr_i == '0)
					load_addr <= AW'(dl_data_i);
				else if (dl_addr_i == AW'(1))
					load_addr[15:8] <= dl_data_i;
				else
					load_addr <= load_addr + 1'b1;
			end

			if (is_crt) begin
				if (dl_addr_i == '0) begin
					load_addr <= loader_pkg::CRT_ROM_BASE;
					blk_len   <= '0;
					hdr_cnt   <= '0;
				end

				if (dl_addr_i == AW'(loader_pkg::CRT_OFS_ID_HI))
					cart_info_o.id[15:8] <= dl_data_i;
				if (dl_addr_i == AW'(loader_pkg::CRT_OFS_ID_LO))
					cart_info_o.id[7:0] <= dl_data_i;
				if (dl_addr_i == AW'(loader_pkg::CRT_OFS_EXROM))
					cart_info_o.exrom <= dl_data_i;
				if (dl_addr_i == AW'(loader_pkg::CRT_OFS_GAME))
					cart_info_o.game <= dl_data_i;
			end

			if (hdr_start) begin
				hdr_cnt <= HCW'(1);
				// Round up to the next bank boundary
				if (load_addr[AB-1:0] != '0)
					load_addr <= {load_addr[AW-1:AB] + 1'b1, {AB{1'b0}}};
			end else if (in_hdr) begin
				// Wraps to zero after the last header byte
				hdr_cnt <= hdr_cnt + 1'b1;
				case (hdr_cnt)
					HCW'(4): blk_len[31:24] <= dl_data_i;
					HCW'(5): blk_len[23:16] <= dl_data_i;
					HCW'(6): blk_len[15:8]  <= dl_data_i;
					HCW'(7): blk_len[7:0]   <= dl_data_i;
					HCW'(8): blk_len <= blk_len - 32'(loader_pkg::CHIP_HDR_BYTES);
					default: ;
				endcase
			end else if (crt_data) begin
				blk_len   <= blk_len - 1'b1;
				load_addr <= load_addr + 1'b1;
			end
		end
	end

	// ==============================
	// Payload registers
	// ==============================
	always_ff @(posedge clk32) begin
		if (data_push) begin
			wr_req_o.addr <= load_addr;
			wr_req_o.data <= dl_data_i;
		end

		if (in_hdr) begin
			case (hdr_cnt)
				HCW'(9):  bank_hdr_o.bank_type       <= dl_data_i;
				HCW'(10): bank_hdr_o.bank_num[15:8]  <= dl_data_i;
				HCW'(11): bank_hdr_o.bank_num[7:0]   <= dl_data_i;
				HCW'(12): bank_hdr_o.load_addr[15:8] <= dl_data_i;
				HCW'(13): bank_hdr_o.load_addr[7:0]  <= dl_data_i;
				HCW'(14): bank_hdr_o.size[15:8]      <= dl_data_i;
				HCW'(15): begin
					bank_hdr_o.size[7:0] <= dl_data_i;
					// Address was aligned at header byte 0
					bank_hdr_o.rom_base  <= load_addr;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/write_queue.sv ====
/*
 * Second loader stage. A circular buffer of pending memory writes between
 * the parser and the slot writer. The registered full level goes back to
 * the host as its wait signal.
 */
`timescale 1ns/1ps
`default_nettype none

module write_queue #(
	parameter int WQ_DEPTH = 4
) (
	input  wire                  clk32,
	input  wire                  rst_n_i,
	input  wire                  push_i,
	input  loader_pkg::mem_wr_t  wr_req_i,
	input  wire                  pop_i,
	output loader_pkg::mem_wr_t  head_o,
	output logic                 not_empty_o,
	output logic                 full_o
);

	localparam int PW = (WQ_DEPTH > 1) ? $clog2(WQ_DEPTH) : 1;
	localparam int CW = $clog2(WQ_DEPTH + 1);

	loader_pkg::mem_wr_t mem [WQ_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] count_next;
	logic          do_push;
	logic          do_pop;

	always_comb begin
		do_pop  = pop_i && (count != '0);
		// A full queue still takes a push when it pops in the same cycle
		do_push = push_i && ((count != CW'(WQ_DEPTH)) || do_pop);
		count_next = count;
		if (do_push && !do_pop)
			count_next = count + 1'b1;
		else if (do_pop && !do_push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk32) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full_o <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(WQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(WQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count  <= count_next;
			full_o <= (count_next == CW'(WQ_DEPTH));
		end
	end

	// Storage
	always_ff @(posedge clk32) begin
		if (do_push)
			mem[wr_ptr] <= wr_req_i;
	end

	assign head_o      = mem[rd_ptr];
	assign not_empty_o = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/slot_writer.sv ====
/*
 * Third loader stage. Takes one queued write at the rising edge of each
 * granted memory slot and holds the write strobe until the slot ends.
 * Slots that arrive while the queue is empty pass unused.
 */
`timescale 1ns/1ps
`default_nettype none

module slot_writer (
	input  wire                                clk32,
	input  wire                                rst_n_i,
	input  wire                                mem_slot_i,
	input  loader_pkg::mem_wr_t                head_i,
	input  wire                                not_empty_i,
	output logic                               pop_o,
	output logic                               mem_we_o,
	output logic [loader_pkg::LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [loader_pkg::DL_DATA_W-1:0]   mem_data_o
);

	logic                slot_d;
	logic                slot_used;
	loader_pkg::mem_wr_t wr_q;

	// Rising edge of the slot with something to write
	assign pop_o = mem_slot_i && !slot_d && not_empty_i;

	always_ff @(posedge clk32) begin
		if (!rst_n_i) begin
			// Starts high so a slot already open at reset release is ignored
			slot_d    <= 1'b1;
			slot_used <= 1'b0;
		end else begin
			slot_d <= mem_slot_i;
			if (pop_o)
				slot_used <= 1'b1;
			else if (!mem_slot_i)
				slot_used <= 1'b0;
		end
	end

	always_ff @(posedge clk32) begin
		if (pop_o)
			wr_q <= head_i;
	end

	assign mem_we_o   = slot_used;
	assign mem_addr_o = wr_q.addr;
	assign mem_data_o = wr_q.data;

endmodule

`default_nettype wire

// ==== verilog/c64_loader_top.sv ====
/*
 * Download loader top level. Chains the parser, the write queue and the
 * slot writer. WQ_DEPTH sets how many writes can wait for memory slots;
 * the host must hold off while dl_wait_o is high.
 */
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top #(
	parameter int WQ_DEPTH = 4
) (
	input  wire                                clk32,
	input  wire                                rst_n_i,
	// Host download side
	input  wire                                dl_active_i,
	input  wire [7:0]                          dl_index_i,
	input  wire                                dl_wr_i,
	input  wire [loader_pkg::LOAD_ADDR_W-1:0]  dl_addr_i,
	input  wire [loader_pkg::DL_DATA_W-1:0]    dl_data_i,
	output logic                               dl_wait_o,
	// Memory slot side
	input  wire                                mem_slot_i,
	output logic                               mem_we_o,
	output logic [loader_pkg::LOAD_ADDR_W-1:0] mem_addr_o,
	output logic [loader_pkg::DL_DATA_W-1:0]   mem_data_o,
	// Cartridge description
	output loader_pkg::cart_info_t             cart_info_o,
	output loader_pkg::bank_hdr_t              bank_hdr_o,
	output logic                               bank_hdr_wr_o
);

	loader_pkg::mem_wr_t wr_req;
	loader_pkg::mem_wr_t head;
	logic                push;
	logic                pop;
	logic                not_empty;

	load_parser u_parser (
		.clk32         (clk32),
		.rst_n_i       (rst_n_i),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.wr_req_o      (wr_req),
		.push_o        (push),
		.cart_info_o   (cart_info_o),
		.bank_hdr_o    (bank_hdr_o),
		.bank_hdr_wr_o (bank_hdr_wr_o)
	);

	write_queue #(
		.WQ_DEPTH (WQ_DEPTH)
	) u_queue (
		.clk32       (clk32),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.wr_req_i    (wr_req),
		.pop_i       (pop),
		.head_o      (head),
		.not_empty_o (not_empty),
		.full_o      (dl_wait_o)
	);

	slot_writer u_writer (
		.clk32       (clk32),
		.rst_n_i     (rst_n_i),
		.mem_slot_i  (mem_slot_i),
		.head_i      (head),
		.not_empty_i (not_empty),
		.pop_o       (pop),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
/*
 * Clock and reset source for the loader testbench.
 * Drives clk32 and holds the active-low reset for the first cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 3
) (
	output logic clk32_o,
	output logic rst_n_o
);

	initial begin
		clk32_o = 1'b0;
		forever #(PERIOD_NS / 2) clk32_o = ~clk32_o;
	end

	// Release on a falling edge so the DUT sees a clean level
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk32_o);
		@(negedge clk32_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/loader_checker.sv ====
/*
 * Concurrent checks on the loader's handshakes.
 * Bound into the loader top level by the testbench.
 */
`timescale 1ns/1ps
`default_nettype none

module loader_checker (
	input wire clk32,
	input wire rst_n_i,
	input wire dl_wr_i,
	input wire dl_wait_i,
	input wire mem_slot_i,
	input wire mem_we_i,
	input wire bank_hdr_wr_i
);

	int unsigned fail_cnt = 0;

	// Host holds off while the queue is full
	no_strobe_while_full: assert property (@(posedge clk32) disable iff (!rst_n_i)
		!(dl_wr_i && dl_wait_i))
	else begin
		$error("dl_wr_i strobed while dl_wait_o was high");
		fail_cnt++;
	end

	// Write strobe only inside a granted slot
	we_inside_slot: assert property (@(posedge clk32) disable iff (!rst_n_i)
		mem_we_i |-> $past(mem_slot_i))
	else begin
		$error("mem_we_o high without a memory slot in the previous cycle");
		fail_cnt++;
	end

	bank_strobe_one_cycle: assert property (@(posedge clk32) disable iff (!rst_n_i)
		bank_hdr_wr_i |=> !bank_hdr_wr_i)
	else begin
		$error("bank_hdr_wr_o stayed high for more than one cycle");
		fail_cnt++;
	end

endmodule

`default_nettype wire

// ==== tests/loader_tb.sv ====
/*
 * Testbench for the download loader. Streams a PRG image and a CRT image
 * with two chip packets from a table, grants memory slots in a fixed pattern
 * and compares every memory write, the cartridge info and the bank records
 * with values worked out from the CRT and PRG layouts.
 */
`timescale 1ns/1ps
`default_nettype none

module loader_tb;

	localparam int WQ_DEPTH = 4;
	localparam int N_TESTS  = 7;
	localparam logic [15:0] CART_ID    = 16'h2013;
	localparam logic [7:0]  CART_EXROM = 8'h01;
	localparam logic [7:0]  CART_GAME  = 8'h02;

	typedef struct packed {
		logic [7:0]                       idx;
		logic [loader_pkg::LOAD_ADDR_W-1:0] ofs;
		logic [7:0]                       data;
		logic                             hold;
		logic                             wr;
	} dl_ent_t;

	wire clk32;
	wire rst_n_i;

	logic                               dl_active_i;
	logic [7:0]                         dl_index_i;
	logic                               dl_wr_i;
	logic [loader_pkg::LOAD_ADDR_W-1:0] dl_addr_i;
	logic [7:0]                         dl_data_i;
	logic                               dl_wait_o;
	logic                               mem_slot_i = 1'b0;
	logic                               mem_we_o;
	logic [loader_pkg::LOAD_ADDR_W-1:0] mem_addr_o;
	logic [7:0]                         mem_data_o;
	loader_pkg::cart_info_t             cart_info_o;
	loader_pkg::bank_hdr_t              bank_hdr_o;
	logic                               bank_hdr_wr_o;

	dl_ent_t                tab[$];
	loader_pkg::mem_wr_t    exp_wr[$];
	int                     exp_test[$];
	loader_pkg::bank_hdr_t  exp_bank[$];

	logic [31:0] lfsr = 32'h503;
	logic        tab_ready = 1'b0;
	logic        slot_hold = 1'b0;
	logic        saw_wait = 1'b0;
	logic        we_prev = 1'b0;
	int          slot_phase = 0;
	int          seen_wr = 0;
	int          seen_bank = 0;
	int          sent_wr = 0;
	int          held_sent = 0;
	int          n_checks = 0;
	int          errs[N_TESTS];
	string       names[N_TESTS] = '{"reset", "program load", "cartridge header",
		"first chip packet", "alignment", "back-pressure", "completion"};

	tb_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) u_clk (
		.clk32_o (clk32),
		.rst_n_o (rst_n_i)
	);

	c64_loader_top #(.WQ_DEPTH(WQ_DEPTH)) dut0 (
		.clk32         (clk32),
		.rst_n_i       (rst_n_i),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.dl_wait_o     (dl_wait_o),
		.mem_slot_i    (mem_slot_i),
		.mem_we_o      (mem_we_o),
		.mem_addr_o    (mem_addr_o),
		.mem_data_o    (mem_data_o),
		.cart_info_o   (cart_info_o),
		.bank_hdr_o    (bank_hdr_o),
		.bank_hdr_wr_o (bank_hdr_wr_o)
	);

	bind c64_loader_top loader_checker u_checker (
		.clk32         (clk32),
		.rst_n_i       (rst_n_i),
		.dl_wr_i       (dl_wr_i),
		.dl_wait_i     (dl_wait_o),
		.mem_slot_i    (mem_slot_i),
		.mem_we_i      (mem_we_o),
		.bank_hdr_wr_i (bank_hdr_wr_o)
	);

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	task automatic add_byte(input logic [7:0] idx, input logic [24:0] ofs,
		input logic [7:0] data, input logic hold, input logic wr);
		tab.push_back('{idx: idx, ofs: ofs, data: data, hold: hold, wr: wr});
	endtask

	task automatic add_data(input logic [7:0] idx, input logic [24:0] ofs,
		input logic [24:0] addr, input logic hold, input int id);
		logic [7:0] d;
		d = rand_byte();
		add_byte(idx, ofs, d, hold, 1'b1);
		exp_wr.push_back('{addr: addr, data: d});
		exp_test.push_back(id);
	endtask

	// One chip packet; the header fields are big-endian
	task automatic add_chip(input logic [24:0] ofs, input logic [7:0] btype,
		input logic [15:0] bnum, input logic [15:0] laddr, input int ndata,
		input logic [24:0] base, input logic hold, input int id);
		logic [127:0] hdr;
		logic [31:0]  len;
		len = 32'(ndata + loader_pkg::CHIP_HDR_BYTES);
		hdr = {32'h43484950, len, 8'h00, btype, bnum, laddr, 16'(ndata)};
		for (int k = 0; k < 16; k++) begin
			add_byte(loader_pkg::IDX_CRT, ofs + 25'(k), hdr[127 - 8 * k -: 8], 1'b0, 1'b0);
		end
		exp_bank.push_back('{bank_type: btype, bank_num: bnum, load_addr: laddr,
			size: 16'(ndata), rom_base: base});
		for (int k = 0; k < ndata; k++) begin
			add_data(loader_pkg::IDX_CRT, ofs + 25'(16 + k), base + 25'(k), hold, id);
		end
	endtask

	task automatic build_table();
		logic [7:0] b;
		add_byte(loader_pkg::IDX_PRG, 25'd0, 8'h01, 1'b0, 1'b0);
		add_byte(loader_pkg::IDX_PRG, 25'd1, 8'h08, 1'b0, 1'b0);
		for (int k = 0; k < 8; k++) begin
			add_data(loader_pkg::IDX_PRG, 25'(2 + k), 25'h801 + 25'(k), 1'b0, 1);
		end
		for (int k = 0; k < 64; k++) begin
			case (8'(k))
				loader_pkg::CRT_OFS_ID_HI: b = CART_ID[15:8];
				loader_pkg::CRT_OFS_ID_LO: b = CART_ID[7:0];
				loader_pkg::CRT_OFS_EXROM: b = CART_EXROM;
				loader_pkg::CRT_OFS_GAME:  b = CART_GAME;
				default:                   b = 8'h00;
			endcase
			add_byte(loader_pkg::IDX_CRT, 25'(k), b, 1'b0, 1'b0);
		end
		// 100 data bytes push the second packet to the next 8 KB bank
		add_chip(25'h40, 8'h00, 16'h0000, 16'h8000, 100, 25'h100000, 1'b0, 3);
		add_chip(25'h40 + 25'd116, 8'h02, 16'h0001, 16'ha000, 20, 25'h102000, 1'b1, 4);
	endtask

	// ==============================
	// Checking helpers
	// ==============================
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int id);
		n_checks++;
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			errs[id]++;
		end
	endtask

	task automatic report_test(input int id);
		$display("Test %0d %s: %s (%0d errors)", id, names[id],
			(errs[id] == 0) ? "passed" : "failed", errs[id]);
	endtask

	task automatic check_idle_outputs();
		compare_value("mem_we_o", 32'(mem_we_o), 32'h0, 0);
		compare_value("bank_hdr_wr_o", 32'(bank_hdr_wr_o), 32'h0, 0);
		compare_value("dl_wait_o", 32'(dl_wait_o), 32'h0, 0);
	endtask

	task automatic check_write();
		loader_pkg::mem_wr_t e;
		int id;
		assert (seen_wr < exp_wr.size()) else begin
			$display("Memory write to %h came after all expected writes", mem_addr_o);
			errs[6]++;
		end
		if (seen_wr < exp_wr.size()) begin
			e  = exp_wr[seen_wr];
			id = exp_test[seen_wr];
			compare_value("mem_addr_o", 32'(mem_addr_o), 32'(e.addr), id);
			compare_value("mem_data_o", 32'(mem_data_o), 32'(e.data), id);
			if (seen_wr + 1 == exp_wr.size() || exp_test[seen_wr + 1] != id)
				report_test(id);
			seen_wr <= seen_wr + 1;
		end
	endtask

	task automatic check_bank();
		loader_pkg::bank_hdr_t e;
		int id;
		assert (seen_bank < exp_bank.size()) else begin
			$display("Bank record strobed after all expected records");
			errs[6]++;
		end
		if (seen_bank < exp_bank.size()) begin
			e  = exp_bank[seen_bank];
			id = 3 + seen_bank;
			compare_value("bank_hdr_o.bank_type", 32'(bank_hdr_o.bank_type), 32'(e.bank_type), id);
			compare_value("bank_hdr_o.bank_num", 32'(bank_hdr_o.bank_num), 32'(e.bank_num), id);
			compare_value("bank_hdr_o.load_addr", 32'(bank_hdr_o.load_addr), 32'(e.load_addr), id);
			compare_value("bank_hdr_o.size", 32'(bank_hdr_o.size), 32'(e.size), id);
			compare_value("bank_hdr_o.rom_base", 32'(bank_hdr_o.rom_base), 32'(e.rom_base), id);
			seen_bank++;
		end
	endtask

	// ==============================
	// Slot pattern and monitor
	// ==============================
	// 2 cycles of slot out of every 6
	always @(negedge clk32) begin
		slot_phase <= (slot_phase == 5) ? 0 : slot_phase + 1;
		mem_slot_i <= (slot_phase < 2) && !slot_hold;
	end

	always @(negedge clk32) begin
		if (rst_n_i && mem_we_o && !we_prev)
			check_write();
		if (rst_n_i && bank_hdr_wr_o)
			check_bank();
		we_prev = mem_we_o;
	end

	initial begin
		wait (tab_ready);
		repeat (tab.size() * 40) @(posedge clk32);
		$display("Timeout: the run did not finish within %0d cycles", tab.size() * 40);
		$display("Finished with errors");
		$finish;
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int failed;
		int total;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = 8'h00;
		for (int t = 0; t < N_TESTS; t++) begin
			errs[t] = 0;
		end
		build_table();
		tab_ready = 1'b1;

		@(negedge clk32);
		while (!rst_n_i) begin
			check_idle_outputs();
			@(negedge clk32);
		end
		check_idle_outputs();
		report_test(0);

		foreach (tab[i]) begin
			if (tab[i].idx == loader_pkg::IDX_CRT &&
				tab[i].ofs == 25'(loader_pkg::CRT_OFS_CHIPS)) begin
				compare_value("cart_info_o.id", 32'(cart_info_o.id), 32'(CART_ID), 2);
				compare_value("cart_info_o.exrom", 32'(cart_info_o.exrom), 32'(CART_EXROM), 2);
				compare_value("cart_info_o.game", 32'(cart_info_o.game), 32'(CART_GAME), 2);
				report_test(2);
			end
			// Start the withheld run with an empty queue
			if (tab[i].hold && !saw_wait && held_sent == 0) begin
				while (seen_wr < sent_wr) @(negedge clk32);
			end
			slot_hold <= tab[i].hold && !saw_wait;
			while (dl_wait_o) begin
				if (tab[i].hold && !saw_wait) begin
					saw_wait = 1'b1;
					slot_hold <= 1'b0;
					assert (held_sent == WQ_DEPTH) else begin
						$display("dl_wait_o rose after %0d withheld writes instead of %0d",
							held_sent, WQ_DEPTH);
						errs[5]++;
					end
				end
				@(negedge clk32);
			end
			dl_active_i = 1'b1;
			dl_index_i  = tab[i].idx;
			dl_addr_i   = tab[i].ofs;
			dl_data_i   = tab[i].data;
			dl_wr_i     = 1'b1;
			if (tab[i].wr)
				sent_wr++;
			if (tab[i].wr && tab[i].hold)
				held_sent++;
			@(negedge clk32);
			dl_wr_i = 1'b0;
			@(negedge clk32);
		end
		dl_active_i = 1'b0;
		slot_hold <= 1'b0;

		while (seen_wr < exp_wr.size()) @(negedge clk32);
		assert (saw_wait) else begin
			$display("dl_wait_o never rose while memory slots were withheld");
			errs[5]++;
		end
		report_test(5);

		// Leave room for any stray write or bank record
		repeat (24) @(negedge clk32);
		assert (seen_bank == exp_bank.size()) else begin
			$display("Saw %0d bank records instead of %0d", seen_bank, exp_bank.size());
			errs[6]++;
		end
		report_test(6);

		failed = 0;
		total  = int'(dut0.u_checker.fail_cnt);
		for (int t = 0; t < N_TESTS; t++) begin
			total += errs[t];
			if (errs[t] != 0)
				failed++;
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			N_TESTS, failed, n_checks, total, dut0.u_checker.fail_cnt);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/loader_pkg.sv
verilog/load_parser.sv
verilog/write_queue.sv
verilog/slot_writer.sv
verilog/c64_loader_top.sv
tests/tb_clock_gen.sv
tests/loader_checker.sv
tests/loader_tb.sv

// ==== Makefile ====
# Verilator build and run of the loader testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module loader_tb -f sources.f

run: compile
	./obj_dir/Vloader_tb +verilator+error+limit+100 > sim.log 2>&1; \
		status=$$?; cat sim.log; exit $$status
	@if grep -q "Finished with errors" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
